// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

  // field widths of the base RV32I encoding
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // architectural register index selects one of x0 to x31
  typedef logic [4:0] reg_idx_t;

  // immediates are always presented already sign extended to the full word
  typedef logic [31:0] imm_t;

  // upper immediate forms
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;

  // control transfer
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;

  // memory access
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;

  // integer arithmetic with an immediate or a second register
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;

  // ordering and environment calls
  // CSR variants share the SYSTEM opcode and are not told apart here
  localparam opcode_t OP_FENCE  = 7'b0001111;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

endpackage

// ==== frontend_pkg.sv ====
package frontend_pkg;

  // one uncompressed instruction as it comes out of fetch
  typedef logic [31:0] instr_word_t;

  // program order number, wide enough that it never wraps in practice
  typedef logic [63:0] order_t;

  // log2 of the number of queue entries, so 4 gives a 16 entry buffer
  localparam int DEFAULT_INSTR_DEPTH = 4;

endpackage

// ==== decode.sv ====
`timescale 1ns/1ps

module decode (
  input  frontend_pkg::instr_word_t inst,
  output rv_isa_pkg::funct3_t       funct3,
  output rv_isa_pkg::funct7_t       funct7,
  output rv_isa_pkg::opcode_t       opcode,
  output rv_isa_pkg::imm_t          imm,
  output rv_isa_pkg::reg_idx_t      rs1_s,
  output rv_isa_pkg::reg_idx_t      rs2_s,
  output rv_isa_pkg::reg_idx_t      rd_s
);

  // candidate immediates, one per encoding format
  rv_isa_pkg::imm_t i_imm;
  rv_isa_pkg::imm_t s_imm;
  rv_isa_pkg::imm_t b_imm;
  rv_isa_pkg::imm_t u_imm;
  rv_isa_pkg::imm_t j_imm;

  // fixed fields sit in the same place for every format
  // so they are sliced without looking at the opcode
  assign opcode = inst[6:0];
  assign rd_s   = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1_s  = inst[19:15];
  assign rs2_s  = inst[24:20];
  assign funct7 = inst[31:25];

  // I format takes the top twelve bits as a signed value
  assign i_imm = {{20{inst[31]}}, inst[31:20]};

  // S format splits the value around the rd slot
  assign s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};

  // B format is a scrambled S layout with an implied zero lsb
  assign b_imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

  // U format fills the upper twenty bits and clears the rest
  assign u_imm = {inst[31:12], 12'b0};

  // J format covers a twenty bit halfword offset
  assign j_imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  // pick the format that the major opcode implies
  always_comb begin
    case (opcode)
      rv_isa_pkg::OP_JALR,
      rv_isa_pkg::OP_LOAD,
      rv_isa_pkg::OP_IMM,
      rv_isa_pkg::OP_SYSTEM: begin
        imm = i_imm;
      end
      rv_isa_pkg::OP_STORE: begin
        imm = s_imm;
      end
      rv_isa_pkg::OP_BRANCH: begin
        imm = b_imm;
      end
      rv_isa_pkg::OP_LUI,
      rv_isa_pkg::OP_AUIPC: begin
        imm = u_imm;
      end
      rv_isa_pkg::OP_JAL: begin
        imm = j_imm;
      end
      // register ops, fence and anything unknown carry no immediate
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

// ==== instruction_queue.sv ====
`timescale 1ns/1ps

module instruction_queue #(
  parameter int INSTR_DEPTH = 4
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      instr_push,
  input  logic                      instr_pop,
  input  frontend_pkg::instr_word_t instr_in,
  input  frontend_pkg::order_t      order_in,
  output logic                      instr_full,
  output logic                      instr_valid_out,
  output frontend_pkg::order_t      order,
  output frontend_pkg::instr_word_t instr,
  output rv_isa_pkg::funct3_t       funct3,
  output rv_isa_pkg::funct7_t       funct7,
  output rv_isa_pkg::opcode_t       opcode,
  output rv_isa_pkg::imm_t          imm,
  output rv_isa_pkg::reg_idx_t      rs1_s,
  output rv_isa_pkg::reg_idx_t      rs2_s,
  output rv_isa_pkg::reg_idx_t      rd_s
);

  localparam int NUM_ENTRIES = 2 ** INSTR_DEPTH;

  // head is the next slot to write and tail the oldest entry
  // both wrap on their own since the depth is a power of two
  logic [INSTR_DEPTH-1:0] head;
  logic [INSTR_DEPTH-1:0] tail;

  frontend_pkg::instr_word_t instr_arr [NUM_ENTRIES];
  frontend_pkg::order_t      order_arr [NUM_ENTRIES];
  logic                      valid_arr [NUM_ENTRIES];

  // a still valid entry under the head means every slot is taken
  assign instr_full = valid_arr[head];

  // tail entry is presented straight away and decoded below
  assign instr           = instr_arr[tail];
  assign order           = order_arr[tail];
  assign instr_valid_out = valid_arr[tail];

  // pointers and valid bits
  // the producer never pushes when full and the consumer never pops when empty,
  // so push and pop never touch the same slot in one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      tail <= '0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        valid_arr[i] <= 1'b0;
      end
    end else begin
      if (instr_pop) begin
        valid_arr[tail] <= 1'b0;
        tail            <= tail + 1'b1;
      end
      if (instr_push) begin
        valid_arr[head] <= 1'b1;
        head            <= head + 1'b1;
      end
    end
  end

  // entry payload, qualified by the valid bits above
  always_ff @(posedge clk) begin
    if (instr_push) begin
      instr_arr[head] <= instr_in;
      order_arr[head] <= order_in;
    end
  end

  decode u_decode (
    .inst   (instr),
    .funct3 (funct3),
    .funct7 (funct7),
    .opcode (opcode),
    .imm    (imm),
    .rs1_s  (rs1_s),
    .rs2_s  (rs2_s),
    .rd_s   (rd_s)
  );

endmodule

// ==== fetch_stamp.sv ====
`timescale 1ns/1ps

module fetch_stamp (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      fetch_valid,
  input  frontend_pkg::instr_word_t fetch_instr,
  output logic                      fetch_stall,
  input  logic                      instr_full,
  output logic                      instr_push,
  output frontend_pkg::instr_word_t instr_in,
  output frontend_pkg::order_t      order_in
);

  // number that the next accepted word will carry
  frontend_pkg::order_t order_cnt;

  // fetch sees the full level directly and has to hold or replay its word
  assign fetch_stall = instr_full;

  // a word is taken only when the queue has a free slot
  assign instr_push = fetch_valid & ~instr_full;

  // the word itself goes through untouched
  assign instr_in = fetch_instr;
  assign order_in = order_cnt;

  // the counter moves only on an accepted word so the numbers stay dense,
  // which lets retirement later check that nothing was skipped
  always_ff @(posedge clk) begin
    if (rst) begin
      order_cnt <= '0;
    end else if (instr_push) begin
      order_cnt <= order_cnt + 64'd1;
    end
  end

endmodule

// ==== dispatch_ctrl.sv ====
`timescale 1ns/1ps

module dispatch_ctrl (
  input  logic                 instr_valid_out,
  input  rv_isa_pkg::opcode_t  opcode,
  input  logic                 issue_ready,
  output logic                 instr_pop,
  output logic                 issue_valid,
  output logic                 uses_rs1,
  output logic                 uses_rs2,
  output logic                 writes_rd,
  output logic                 illegal
);

  // the tail entry is offered whenever it holds something
  assign issue_valid = instr_valid_out;

  // the queue trusts this pulse, so validity is checked only here
  assign instr_pop = instr_valid_out & issue_ready;

  // register usage tells rename which sources to look up
  // and whether a new physical destination is needed
  always_comb begin
    uses_rs1  = 1'b0;
    uses_rs2  = 1'b0;
    writes_rd = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_LUI,
      rv_isa_pkg::OP_AUIPC,
      rv_isa_pkg::OP_JAL: begin
        writes_rd = 1'b1;
      end
      rv_isa_pkg::OP_JALR,
      rv_isa_pkg::OP_LOAD,
      rv_isa_pkg::OP_IMM: begin
        uses_rs1  = 1'b1;
        writes_rd = 1'b1;
      end
      rv_isa_pkg::OP_BRANCH,
      rv_isa_pkg::OP_STORE: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      rv_isa_pkg::OP_REG: begin
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b1;
        writes_rd = 1'b1;
      end
      // fence and system touch no integer register at this stage
      rv_isa_pkg::OP_FENCE,
      rv_isa_pkg::OP_SYSTEM: begin
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== frontend_top.sv ====
`timescale 1ns/1ps

module frontend_top #(
  parameter int INSTR_DEPTH = frontend_pkg::DEFAULT_INSTR_DEPTH
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      fetch_valid,
  input  frontend_pkg::instr_word_t fetch_instr,
  output logic                      fetch_stall,
  input  logic                      issue_ready,
  output logic                      issue_valid,
  output frontend_pkg::order_t      order,
  output frontend_pkg::instr_word_t instr,
  output rv_isa_pkg::funct3_t       funct3,
  output rv_isa_pkg::funct7_t       funct7,
  output rv_isa_pkg::opcode_t       opcode,
  output rv_isa_pkg::imm_t          imm,
  output rv_isa_pkg::reg_idx_t      rs1_s,
  output rv_isa_pkg::reg_idx_t      rs2_s,
  output rv_isa_pkg::reg_idx_t      rd_s,
  output logic                      uses_rs1,
  output logic                      uses_rs2,
  output logic                      writes_rd,
  output logic                      illegal
);

  // stamping to queue
  logic                      instr_full;
  logic                      instr_push;
  frontend_pkg::instr_word_t instr_in;
  frontend_pkg::order_t      order_in;

  // queue to dispatch
  logic instr_valid_out;
  logic instr_pop;

  fetch_stamp u_fetch_stamp (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .fetch_stall (fetch_stall),
    .instr_full  (instr_full),
    .instr_push  (instr_push),
    .instr_in    (instr_in),
    .order_in    (order_in)
  );

  instruction_queue #(
    .INSTR_DEPTH (INSTR_DEPTH)
  ) u_instruction_queue (
    .clk             (clk),
    .rst             (rst),
    .instr_push      (instr_push),
    .instr_pop       (instr_pop),
    .instr_in        (instr_in),
    .order_in        (order_in),
    .instr_full      (instr_full),
    .instr_valid_out (instr_valid_out),
    .order           (order),
    .instr           (instr),
    .funct3          (funct3),
    .funct7          (funct7),
    .opcode          (opcode),
    .imm             (imm),
    .rs1_s           (rs1_s),
    .rs2_s           (rs2_s),
    .rd_s            (rd_s)
  );

  // decoded fields leave the top as is, only the opcode is needed for the flags
  dispatch_ctrl u_dispatch_ctrl (
    .instr_valid_out (instr_valid_out),
    .opcode          (opcode),
    .issue_ready     (issue_ready),
    .instr_pop       (instr_pop),
    .issue_valid     (issue_valid),
    .uses_rs1        (uses_rs1),
    .uses_rs2        (uses_rs2),
    .writes_rd       (writes_rd),
    .illegal         (illegal)
  );

endmodule

// ==== frontend_properties.sv ====
`timescale 1ns/1ps

module frontend_properties (
  input logic clk,
  input logic rst,
  input logic instr_push,
  input logic instr_pop,
  input logic instr_full,
  input logic instr_valid_out
);

  // number of assertion failures, read by the testbench at the end of the run
  int fail_count = 0;

  // the stamping block has to hold back a word while every slot is taken
  push_while_full: assert property (
    @(posedge clk) disable iff (rst) instr_full |-> !instr_push
  ) else begin
    fail_count++;
    $error("push issued while the queue is full");
  end

  // the queue pops blindly, so dispatch must only pop a valid tail
  pop_while_empty: assert property (
    @(posedge clk) disable iff (rst) !instr_valid_out |-> !instr_pop
  ) else begin
    fail_count++;
    $error("pop issued while the tail entry is not valid");
  end

  // reset clears every valid bit, so nothing is offered in the next cycle
  valid_after_reset: assert property (
    @(posedge clk) rst |=> !instr_valid_out
  ) else begin
    fail_count++;
    $error("tail valid still high in the cycle after reset");
  end

endmodule

bind instruction_queue frontend_properties u_frontend_properties (
  .clk             (clk),
  .rst             (rst),
  .instr_push      (instr_push),
  .instr_pop       (instr_pop),
  .instr_full      (instr_full),
  .instr_valid_out (instr_valid_out)
);

// ==== tb_frontend.sv ====
`timescale 1ns/1ps

module tb_frontend;

  localparam int INSTR_DEPTH    = frontend_pkg::DEFAULT_INSTR_DEPTH;
  localparam int NUM_ENTRIES    = 2 ** INSTR_DEPTH;
  localparam int RESET_CYCLES   = 8;
  localparam int STIM_CYCLES    = 3000;
  localparam int DRAIN_CYCLES   = NUM_ENTRIES + 8;
  // reset and drain add a few dozen cycles, so this leaves a wide margin
  localparam int TIMEOUT_CYCLES = STIM_CYCLES + 1000;

  logic clk;
  logic rst;
  logic fetch_valid;
  frontend_pkg::instr_word_t fetch_instr;
  logic fetch_stall;
  logic issue_ready;
  logic issue_valid;
  frontend_pkg::order_t order;
  frontend_pkg::instr_word_t instr;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::funct7_t funct7;
  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::imm_t imm;
  rv_isa_pkg::reg_idx_t rs1_s;
  rv_isa_pkg::reg_idx_t rs2_s;
  rv_isa_pkg::reg_idx_t rd_s;
  logic uses_rs1;
  logic uses_rs2;
  logic writes_rd;
  logic illegal;

  int seed;
  int cycle_count = 0;
  // set when the word offered at the last edge was refused and must be held
  logic word_pending;

  // reference FIFO of accepted words and the order numbers they should carry
  frontend_pkg::instr_word_t model_words [$];
  frontend_pkg::order_t model_orders [$];
  frontend_pkg::order_t model_next_order;

  frontend_top #(
    .INSTR_DEPTH (INSTR_DEPTH)
  ) UUT (
    .clk         (clk),
    .rst         (rst),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .fetch_stall (fetch_stall),
    .issue_ready (issue_ready),
    .issue_valid (issue_valid),
    .order       (order),
    .instr       (instr),
    .funct3      (funct3),
    .funct7      (funct7),
    .opcode      (opcode),
    .imm         (imm),
    .rs1_s       (rs1_s),
    .rs2_s       (rs2_s),
    .rd_s        (rd_s),
    .uses_rs1    (uses_rs1),
    .uses_rs2    (uses_rs2),
    .writes_rd   (writes_rd),
    .illegal     (illegal)
  );

  always #5 clk = ~clk;

  // watchdog on the total run length
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $fatal(1, "timeout");
    end
  end

  function automatic int random_below(input int limit);
    return $unsigned($random(seed)) % limit;
  endfunction

  // random word with a listed opcode, or now and then one outside the ISA list
  function automatic frontend_pkg::instr_word_t random_instr();
    logic [31:0] bits;
    rv_isa_pkg::opcode_t opc;
    bits = $random(seed);
    case (random_below(12))
      0: opc = rv_isa_pkg::OP_LUI;
      1: opc = rv_isa_pkg::OP_AUIPC;
      2: opc = rv_isa_pkg::OP_JAL;
      3: opc = rv_isa_pkg::OP_JALR;
      4: opc = rv_isa_pkg::OP_BRANCH;
      5: opc = rv_isa_pkg::OP_LOAD;
      6: opc = rv_isa_pkg::OP_STORE;
      7: opc = rv_isa_pkg::OP_IMM;
      8: opc = rv_isa_pkg::OP_REG;
      9: opc = rv_isa_pkg::OP_FENCE;
      10: opc = rv_isa_pkg::OP_SYSTEM;
      default: opc = 7'b1111011;
    endcase
    return {bits[31:7], opc};
  endfunction

  // immediate built with arithmetic shifts, then the scrambled low bits patched in
  function automatic rv_isa_pkg::imm_t expected_imm(input frontend_pkg::instr_word_t w);
    logic signed [31:0] sw;
    rv_isa_pkg::imm_t r;
    sw = w;
    r = '0;
    case (w[6:0])
      rv_isa_pkg::OP_JALR, rv_isa_pkg::OP_LOAD, rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_SYSTEM: begin
        r = sw >>> 20;
      end
      rv_isa_pkg::OP_STORE: begin
        r = sw >>> 20;
        r[4:0] = w[11:7];
      end
      rv_isa_pkg::OP_BRANCH: begin
        r = sw >>> 19;
        r[11:0] = {w[7], w[30:25], w[11:8], 1'b0};
      end
      rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC: begin
        r = w & 32'hffff_f000;
      end
      rv_isa_pkg::OP_JAL: begin
        r = sw >>> 11;
        r[19:0] = {w[19:12], w[20], w[30:21], 1'b0};
      end
      default: begin
        r = '0;
      end
    endcase
    return r;
  endfunction

  // flags packed as uses_rs1, uses_rs2, writes_rd, illegal
  function automatic logic [3:0] expected_flags(input rv_isa_pkg::opcode_t opc);
    logic rs1;
    logic rs2;
    logic rd;
    logic known;
    rs1 = opc inside {rv_isa_pkg::OP_JALR, rv_isa_pkg::OP_BRANCH, rv_isa_pkg::OP_LOAD,
                      rv_isa_pkg::OP_STORE, rv_isa_pkg::OP_IMM, rv_isa_pkg::OP_REG};
    rs2 = opc inside {rv_isa_pkg::OP_BRANCH, rv_isa_pkg::OP_STORE, rv_isa_pkg::OP_REG};
    rd = opc inside {rv_isa_pkg::OP_LUI, rv_isa_pkg::OP_AUIPC, rv_isa_pkg::OP_JAL,
                     rv_isa_pkg::OP_JALR, rv_isa_pkg::OP_LOAD, rv_isa_pkg::OP_IMM,
                     rv_isa_pkg::OP_REG};
    known = rs1 | rs2 | rd |
            (opc inside {rv_isa_pkg::OP_FENCE, rv_isa_pkg::OP_SYSTEM});
    return {rs1, rs2, rd, ~known};
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] want);
    if (got !== want) begin
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, want);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // runs at the falling edge once the inputs are driven
  // every compared output depends only on queue state, which is settled half a cycle
  // after the rising edge, and the model then applies what the coming rising edge does
  task automatic check_cycle();
    frontend_pkg::instr_word_t w;
    logic [3:0] flags;
    check_value("fetch_stall", fetch_stall, model_words.size() == NUM_ENTRIES);
    check_value("issue_valid", issue_valid, model_words.size() != 0);
    if (issue_valid && issue_ready) begin
      w = model_words.pop_front();
      flags = expected_flags(w[6:0]);
      check_value("order", order, model_orders.pop_front());
      check_value("instr", instr, w);
      check_value("opcode", opcode, w[6:0]);
      check_value("rd_s", rd_s, w[11:7]);
      check_value("funct3", funct3, w[14:12]);
      check_value("rs1_s", rs1_s, w[19:15]);
      check_value("rs2_s", rs2_s, w[24:20]);
      check_value("funct7", funct7, w[31:25]);
      check_value("imm", imm, expected_imm(w));
      check_value("uses_rs1", uses_rs1, flags[3]);
      check_value("uses_rs2", uses_rs2, flags[2]);
      check_value("writes_rd", writes_rd, flags[1]);
      check_value("illegal", illegal, flags[0]);
    end
    word_pending = fetch_valid && fetch_stall;
    if (fetch_valid && !fetch_stall) begin
      model_words.push_back(fetch_instr);
      model_orders.push_back(model_next_order);
      model_next_order++;
    end
  endtask

  // ready rate moves through phases, one of them holding rename off entirely
  task automatic drive_inputs(input int cycle);
    int rate;
    if (!word_pending) begin
      fetch_valid = random_below(100) < 60;
      fetch_instr = random_instr();
    end
    case ((cycle / 250) % 4)
      0: rate = 90;
      1: rate = 50;
      2: rate = 0;
      default: rate = 20;
    endcase
    issue_ready = random_below(100) < rate;
  endtask

  initial begin
    seed = 32'haadf_a57e;
    clk = 1'b0;
    rst = 1'b1;
    fetch_valid = 1'b0;
    fetch_instr = '0;
    issue_ready = 1'b0;
    word_pending = 1'b0;
    model_next_order = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_value("fetch_stall after reset", fetch_stall, 1'b0);
    check_value("issue_valid after reset", issue_valid, 1'b0);
    for (int i = 0; i < STIM_CYCLES; i++) begin
      drive_inputs(i);
      check_cycle();
      @(negedge clk);
    end
    // drain whatever is still queued with rename always ready
    fetch_valid = 1'b0;
    issue_ready = 1'b1;
    repeat (DRAIN_CYCLES) begin
      check_cycle();
      @(negedge clk);
    end
    if (model_words.size() == 0 &&
        UUT.u_instruction_queue.u_frontend_properties.fail_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("run ended with %0d words never issued or with a failed assertion",
               model_words.size());
      $display("TEST FAILED");
      $fatal(1, "end of run check");
    end
  end

endmodule

// ==== frontend.f ====
rv_isa_pkg.sv
frontend_pkg.sv
decode.sv
instruction_queue.sv
fetch_stamp.sv
dispatch_ctrl.sv
frontend_top.sv
frontend_properties.sv
tb_frontend.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_frontend \
		-f frontend.f -o sim_frontend
	./obj_dir/sim_frontend | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
